//--- compile.f
design/rv_isa_pkg.sv
design/core_pkg.sv
design/alu.sv
design/fetch_unit.sv
design/decoder.sv
design/regfile.sv
design/execute_unit.sv
design/rv32_core.sv
tb/rv32_core_props.sv
tb/rv32_core_tb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module rv32_core_tb -f compile.f -o rv32_core_sim \
    && ./obj_dir/rv32_core_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Testbench failed" sim.log && exit 1
grep -q "Testbench passed" sim.log || exit 1
exit 0

//--- tb/rv32_core_tb.sv
`timescale 1ns/1ps

module rv32_core_tb
    import rv_isa_pkg::*;
();
    localparam logic [31:0] RESET_VECTOR = 32'h8000_0000;
    localparam logic [31:0] NOP          = 32'h0000_0013; // addi x0, x0, 0

    logic        clk;
    logic        reset;
    logic [31:0] inst;
    logic [31:0] pc;
    logic        wb_en;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;

    // program table, one entry per executed instruction
    logic [31:0] inst_q[$];
    logic [31:0] pc_q[$];
    logic        wen_q[$];
    logic [4:0]  addr_q[$];
    logic [31:0] data_q[$];
    logic [31:0] build_pc; // pc of the row being added
    int          errors;
    int          row;
    int          cycles;

    rv32_core i_rv32_core (
        .clk     (clk),
        .reset   (reset),
        .inst    (inst),
        .pc      (pc),
        .wb_en   (wb_en),
        .wb_addr (wb_addr),
        .wb_data (wb_data)
    );

    bind rv32_core rv32_core_props #(.RESET_PC(RESET_PC)) i_rv32_core_props (
        .clk(clk), .reset(reset), .pc(pc), .wb_en(wb_en), .wb_addr(wb_addr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // also covers R format with {funct7, rs2} as the immediate
    function automatic logic [31:0] i_format(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] b_format(input logic [12:0] imm, input logic [4:0] rs1,
            input logic [4:0] rs2, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] u_format(input logic [19:0] imm, input logic [4:0] rd,
            input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_format(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    // step is the distance from this row's pc to the next row's pc
    task automatic add_row(input logic [31:0] word, input int step, input logic wen,
            input logic [4:0] addr, input logic [31:0] data);
        inst_q.push_back(word);
        pc_q.push_back(build_pc);
        wen_q.push_back(wen);
        addr_q.push_back(addr);
        data_q.push_back(data);
        build_pc = build_pc + step;
    endtask

    initial begin
        errors = 0;
        build_pc = RESET_VECTOR;
        reset <= 1'b1;
        inst <= NOP;

        // x1 = 5, x2 = -3
        add_row(i_format(12'd5, 5'd0, 3'b000, 5'd1, OPC_OP_IMM), 4, 1'b1, 5'd1, 32'h5);
        add_row(i_format(12'hffd, 5'd0, 3'b000, 5'd2, OPC_OP_IMM), 4, 1'b1, 5'd2, 32'hffff_fffd);
        // register forms
        add_row(i_format({F7_ALT, 5'd2}, 5'd1, 3'b000, 5'd3, OPC_OP), 4, 1'b1, 5'd3, 32'h8);
        add_row(i_format({7'd0, 5'd1}, 5'd1, 3'b001, 5'd4, OPC_OP), 4, 1'b1, 5'd4, 32'ha0);
        add_row(i_format({7'd0, 5'd1}, 5'd2, 3'b010, 5'd5, OPC_OP), 4, 1'b1, 5'd5, 32'h1);
        add_row(i_format({7'd0, 5'd1}, 5'd2, 3'b011, 5'd6, OPC_OP), 4, 1'b1, 5'd6, 32'h0);
        add_row(i_format({7'd0, 5'd2}, 5'd1, 3'b100, 5'd7, OPC_OP), 4, 1'b1, 5'd7, 32'hffff_fff8);
        add_row(i_format({7'd0, 5'd1}, 5'd2, 3'b101, 5'd8, OPC_OP), 4, 1'b1, 5'd8, 32'h07ff_ffff);
        add_row(i_format({F7_ALT, 5'd1}, 5'd2, 3'b101, 5'd9, OPC_OP), 4, 1'b1, 5'd9, 32'hffff_ffff);
        add_row(i_format({7'd0, 5'd2}, 5'd1, 3'b110, 5'd10, OPC_OP), 4, 1'b1, 5'd10, 32'hffff_fffd);
        add_row(i_format({7'd0, 5'd2}, 5'd1, 3'b111, 5'd11, OPC_OP), 4, 1'b1, 5'd11, 32'h5);
        // immediate forms
        add_row(i_format({7'd0, 5'd3}, 5'd1, 3'b001, 5'd12, OPC_OP_IMM), 4, 1'b1, 5'd12, 32'h28);
        add_row(i_format(12'hffe, 5'd2, 3'b010, 5'd13, OPC_OP_IMM), 4, 1'b1, 5'd13, 32'h1);
        add_row(i_format(12'hfff, 5'd1, 3'b011, 5'd14, OPC_OP_IMM), 4, 1'b1, 5'd14, 32'h1);
        add_row(i_format(12'h0ff, 5'd1, 3'b100, 5'd15, OPC_OP_IMM), 4, 1'b1, 5'd15, 32'hfa);
        add_row(i_format({7'd0, 5'd4}, 5'd2, 3'b101, 5'd16, OPC_OP_IMM), 4, 1'b1, 5'd16,
                32'h0fff_ffff);
        add_row(i_format({F7_ALT, 5'd1}, 5'd2, 3'b101, 5'd17, OPC_OP_IMM), 4, 1'b1, 5'd17,
                32'hffff_fffe);
        add_row(i_format(12'h030, 5'd1, 3'b110, 5'd18, OPC_OP_IMM), 4, 1'b1, 5'd18, 32'h35);
        add_row(i_format(12'h0f0, 5'd2, 3'b111, 5'd19, OPC_OP_IMM), 4, 1'b1, 5'd19, 32'hf0);
        add_row(u_format(20'h12345, 5'd20, OPC_LUI), 4, 1'b1, 5'd20, 32'h1234_5000);
        add_row(u_format(20'h00001, 5'd21, OPC_AUIPC), 4, 1'b1, 5'd21, build_pc + 32'h1000);
        // each branch condition taken, then not taken
        add_row(b_format(13'd16, 5'd1, 5'd1, F3_BEQ), 16, 1'b0, 5'd0, 32'h0);
        add_row(b_format(13'd16, 5'd1, 5'd2, F3_BEQ), 4, 1'b0, 5'd0, 32'h0);
        add_row(b_format(13'h1ff8, 5'd1, 5'd2, F3_BNE), -8, 1'b0, 5'd0, 32'h0);
        add_row(b_format(13'd8, 5'd1, 5'd1, F3_BNE), 4, 1'b0, 5'd0, 32'h0);
        add_row(b_format(13'd12, 5'd2, 5'd1, F3_BLT), 12, 1'b0, 5'd0, 32'h0);
        add_row(b_format(13'd12, 5'd1, 5'd2, F3_BLT), 4, 1'b0, 5'd0, 32'h0);
        add_row(b_format(13'd20, 5'd1, 5'd2, F3_BGE), 20, 1'b0, 5'd0, 32'h0);
        add_row(b_format(13'd20, 5'd2, 5'd1, F3_BGE), 4, 1'b0, 5'd0, 32'h0);
        add_row(b_format(13'd24, 5'd1, 5'd2, F3_BLTU), 24, 1'b0, 5'd0, 32'h0);
        add_row(b_format(13'd24, 5'd2, 5'd1, F3_BLTU), 4, 1'b0, 5'd0, 32'h0);
        add_row(b_format(13'd8, 5'd2, 5'd1, F3_BGEU), 8, 1'b0, 5'd0, 32'h0);
        add_row(b_format(13'd8, 5'd1, 5'd2, F3_BGEU), 4, 1'b0, 5'd0, 32'h0);
        // jal, then jalr off x23 = its own pc - 4 with an odd sum
        add_row(j_format(21'd256, 5'd22), 256, 1'b1, 5'd22, build_pc + 32'h4);
        add_row(u_format(20'h0, 5'd23, OPC_AUIPC), 4, 1'b1, 5'd23, build_pc);
        add_row(i_format(12'd13, 5'd23, 3'b000, 5'd24, OPC_JALR), 8, 1'b1, 5'd24, build_pc + 32'h4);
        // x0 stays zero, store opcode is ignored
        add_row(i_format(12'd7, 5'd1, 3'b000, 5'd0, OPC_OP_IMM), 4, 1'b0, 5'd0, 32'h0);
        add_row(i_format({7'd0, 5'd1}, 5'd0, 3'b000, 5'd25, OPC_OP), 4, 1'b1, 5'd25, 32'h5);
        add_row(i_format({7'd0, 5'd1}, 5'd2, 3'b010, 5'd27, 7'b0100011), 4, 1'b0, 5'd0, 32'h0);
        add_row(i_format(12'd1, 5'd25, 3'b000, 5'd26, OPC_OP_IMM), 4, 1'b1, 5'd26, 32'h6);

        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            if (i == 7) begin
                inst <= inst_q[0]; // row 0 already present in the last reset cycle
            end
            @(negedge clk);
            if (wb_en !== 1'b0) begin
                $display("** Error in reset: wb_en expected 0, got %h", wb_en);
                errors++;
            end
        end
        @(posedge clk);
        reset <= 1'b0;

        row = 0;
        cycles = 0;
        while (row < inst_q.size() && cycles < inst_q.size() + 20) begin
            @(negedge clk); // outputs settled mid cycle
            cycles++;
            if (pc !== pc_q[row]) begin
                $display("** Error row %0d: pc expected %h, got %h", row, pc_q[row], pc);
                errors++;
            end
            if (wb_en !== wen_q[row]) begin
                $display("** Error row %0d: wb_en expected %h, got %h", row, wen_q[row], wb_en);
                errors++;
            end
            if (wen_q[row] && wb_addr !== addr_q[row]) begin
                $display("** Error row %0d: wb_addr expected %h, got %h", row, addr_q[row],
                         wb_addr);
                errors++;
            end
            if (wen_q[row] && wb_data !== data_q[row]) begin
                $display("** Error row %0d: wb_data expected %h, got %h", row, data_q[row],
                         wb_data);
                errors++;
            end
            row++;
            @(posedge clk);
            if (row < inst_q.size()) begin
                inst <= inst_q[row];
            end
        end
        if (row < inst_q.size()) begin
            $display("Timeout: only %0d of %0d rows ran in %0d cycles", row, inst_q.size(), cycles);
            errors++;
        end

        $display("Rows checked: %0d, errors: %0d", row, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- tb/rv32_core_props.sv
`timescale 1ns/1ps

module rv32_core_props
    import core_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = 32'h8000_0000
) (
    input logic                  clk,
    input logic                  reset,
    input logic [XLEN-1:0]       pc,
    input logic                  wb_en,
    input logic [REG_ADDR_W-1:0] wb_addr
);

    pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[0] == 1'b0)
        else $error("pc is not halfword aligned");

    no_x0_write: assert property (@(posedge clk) wb_en |-> wb_addr != '0)
        else $error("writeback enabled for x0");

    // the register file must stay untouched while held in reset
    quiet_in_reset: assert property (@(posedge clk) reset |-> !wb_en)
        else $error("writeback enabled during reset");

    reset_vector: assert property (@(posedge clk) $fell(reset) |-> pc == RESET_PC)
        else $error("pc is not at the reset vector after reset");

endmodule

//--- design/rv32_core.sv
`timescale 1ns/1ps

module rv32_core
    import core_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = 32'h8000_0000
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [XLEN-1:0]       inst,
    output logic [XLEN-1:0]       pc,
    output logic                  wb_en,
    output logic [REG_ADDR_W-1:0] wb_addr,
    output logic [XLEN-1:0]       wb_data
);
    logic [XLEN-1:0]       snpc;
    logic                  jump_en;
    logic [XLEN-1:0]       jump_target;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic                  rd_write;
    logic [KIND_W-1:0]     kind;
    logic [ALU_OP_W-1:0]   alu_op;
    logic [2:0]            funct3;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       src1;
    logic [XLEN-1:0]       src2;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) i_fetch_unit (
        .clk         (clk),
        .reset       (reset),
        .jump_en     (jump_en),
        .jump_target (jump_target),
        .pc          (pc),
        .snpc        (snpc)
    );

    decoder i_decoder (
        .inst     (inst),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (wb_addr), // destination index goes straight out
        .rd_write (rd_write),
        .kind     (kind),
        .alu_op   (alu_op),
        .funct3   (funct3),
        .imm      (imm)
    );

    regfile i_regfile (
        .clk      (clk),
        .reset    (reset),
        .rd_write (rd_write),
        .waddr    (wb_addr),
        .wdata    (wb_data),
        .raddr1   (rs1),
        .raddr2   (rs2),
        .rdata1   (src1),
        .rdata2   (src2),
        .wb_en    (wb_en)
    );

    execute_unit i_execute_unit (
        .kind        (kind),
        .alu_op      (alu_op),
        .funct3      (funct3),
        .src1        (src1),
        .src2        (src2),
        .imm         (imm),
        .pc          (pc),
        .snpc        (snpc),
        .wb_value    (wb_data),
        .jump_en     (jump_en),
        .jump_target (jump_target)
    );

endmodule

//--- design/execute_unit.sv
`timescale 1ns/1ps

module execute_unit
    import core_pkg::*, rv_isa_pkg::*;
(
    input  logic [KIND_W-1:0]   kind,
    input  logic [ALU_OP_W-1:0] alu_op,
    input  logic [2:0]          funct3,
    input  logic [XLEN-1:0]     src1,
    input  logic [XLEN-1:0]     src2,
    input  logic [XLEN-1:0]     imm,
    input  logic [XLEN-1:0]     pc,
    input  logic [XLEN-1:0]     snpc,
    output logic [XLEN-1:0]     wb_value,
    output logic                jump_en,
    output logic [XLEN-1:0]     jump_target
);
    logic [XLEN-1:0] alu_a;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_result;
    logic            taken; // branch condition holds

    alu i_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result)
    );

    // operand selection
    always_comb begin
        case (kind)
            KIND_OP: begin
                alu_a = src1;
                alu_b = src2;
            end
            KIND_OP_IMM, KIND_JALR: begin
                alu_a = src1;
                alu_b = imm;
            end
            KIND_LUI: begin
                alu_a = '0;
                alu_b = imm;
            end
            default: begin // auipc, jal, branch
                alu_a = pc;
                alu_b = imm;
            end
        endcase
    end

    always_comb begin
        case (funct3)
            F3_BEQ:  taken = (src1 == src2);
            F3_BNE:  taken = (src1 != src2);
            F3_BLT:  taken = ($signed(src1) < $signed(src2));
            F3_BGE:  taken = ($signed(src1) >= $signed(src2));
            F3_BLTU: taken = (src1 < src2);
            F3_BGEU: taken = (src1 >= src2);
            default: taken = 1'b0; // reserved encodings fall through
        endcase
    end

    assign jump_en = (kind == KIND_JAL) || (kind == KIND_JALR) ||
                     ((kind == KIND_BRANCH) && taken);

    // jalr target drops bit 0
    assign jump_target = (kind == KIND_JALR) ? {alu_result[XLEN-1:1], 1'b0} : alu_result;

    always_comb begin
        case (kind)
            KIND_JAL, KIND_JALR: wb_value = snpc; // link address
            KIND_OP, KIND_OP_IMM, KIND_LUI, KIND_AUIPC: wb_value = alu_result;
            default: wb_value = '0;
        endcase
    end

endmodule

//--- design/regfile.sv
`timescale 1ns/1ps

module regfile
    import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  rd_write,
    input  logic [REG_ADDR_W-1:0] waddr,
    input  logic [XLEN-1:0]       wdata,
    input  logic [REG_ADDR_W-1:0] raddr1,
    input  logic [REG_ADDR_W-1:0] raddr2,
    output logic [XLEN-1:0]       rdata1,
    output logic [XLEN-1:0]       rdata2,
    output logic                  wb_en
);
    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    // no writes while the core is held in reset
    assign wb_en = rd_write && !reset;

    always_ff @(posedge clk) begin
        if (wb_en) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 is hardwired to zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- design/decoder.sv
`timescale 1ns/1ps

module decoder
    import core_pkg::*, rv_isa_pkg::*;
(
    input  logic [XLEN-1:0]       inst,
    output logic [REG_ADDR_W-1:0] rs1,
    output logic [REG_ADDR_W-1:0] rs2,
    output logic [REG_ADDR_W-1:0] rd,
    output logic                  rd_write,
    output logic [KIND_W-1:0]     kind,
    output logic [ALU_OP_W-1:0]   alu_op,
    output logic [2:0]            funct3,
    output logic [XLEN-1:0]       imm
);
    inst_word_u iw;
    logic       writes_reg; // kind produces a register result

    assign iw     = inst;
    assign rs1    = iw.r.rs1;
    assign rs2    = iw.r.rs2;
    assign rd     = iw.r.rd;
    assign funct3 = iw.r.funct3;

    always_comb begin
        case (iw.r.opcode)
            OPC_OP:     kind = KIND_OP;
            OPC_OP_IMM: kind = KIND_OP_IMM;
            OPC_LUI:    kind = KIND_LUI;
            OPC_AUIPC:  kind = KIND_AUIPC;
            OPC_JAL:    kind = KIND_JAL;
            OPC_JALR:   kind = KIND_JALR;
            OPC_BRANCH: kind = KIND_BRANCH;
            default:    kind = KIND_NONE; // loads, stores, system...
        endcase
    end

    always_comb begin
        case (kind)
            KIND_OP_IMM, KIND_JALR: imm = {{20{iw.i.imm_11_0[11]}}, iw.i.imm_11_0};
            KIND_BRANCH: imm = {{19{iw.b.imm_12}}, iw.b.imm_12, iw.b.imm_11,
                                iw.b.imm_10_5, iw.b.imm_4_1, 1'b0};
            KIND_LUI, KIND_AUIPC: imm = {iw.u.imm_31_12, 12'b0};
            KIND_JAL: imm = {{11{iw.j.imm_20}}, iw.j.imm_20, iw.j.imm_19_12,
                             iw.j.imm_11, iw.j.imm_10_1, 1'b0};
            default: imm = '0;
        endcase
    end

    always_comb begin
        alu_op = ALU_ADD; // address sums and lui/auipc
        if (kind == KIND_OP || kind == KIND_OP_IMM) begin
            case (iw.r.funct3)
                3'b000: alu_op = (kind == KIND_OP && iw.r.funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
                3'b001: alu_op = ALU_SLL;
                3'b010: alu_op = ALU_SLT;
                3'b011: alu_op = ALU_SLTU;
                3'b100: alu_op = ALU_XOR;
                3'b101: alu_op = (iw.r.funct7 == F7_ALT) ? ALU_SRA : ALU_SRL; // srai shares bit 30
                3'b110: alu_op = ALU_OR;
                default: alu_op = ALU_AND;
            endcase
        end
    end

    assign writes_reg = (kind == KIND_OP) || (kind == KIND_OP_IMM) || (kind == KIND_LUI) ||
                        (kind == KIND_AUIPC) || (kind == KIND_JAL) || (kind == KIND_JALR);
    assign rd_write   = writes_reg && (iw.r.rd != '0); // x0 never written

endmodule

//--- design/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit
    import core_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = 32'h8000_0000
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            jump_en,
    input  logic [XLEN-1:0] jump_target,
    output logic [XLEN-1:0] pc,
    output logic [XLEN-1:0] snpc
);
    logic [XLEN-1:0] dnpc; // pc of the next instruction

    assign snpc = pc + XLEN'(4);
    assign dnpc = jump_en ? jump_target : snpc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC; // reset vector
        end else begin
            pc <= dnpc;
        end
    end

endmodule

//--- design/alu.sv
`timescale 1ns/1ps

module alu
    import core_pkg::*;
(
    input  logic [XLEN-1:0]     a,
    input  logic [XLEN-1:0]     b,
    input  logic [ALU_OP_W-1:0] op,
    output logic [XLEN-1:0]     result
);
    logic [4:0] shamt;

    assign shamt = b[4:0]; // only low five bits count

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, a < b};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $unsigned($signed(a) >>> shamt); // keeps sign bit
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0;
        endcase
    end

endmodule

//--- design/core_pkg.sv
package core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // instruction kinds after decode
    localparam int KIND_W = 3;
    localparam logic [KIND_W-1:0] KIND_NONE   = 3'd0; // unsupported, no effect
    localparam logic [KIND_W-1:0] KIND_OP     = 3'd1;
    localparam logic [KIND_W-1:0] KIND_OP_IMM = 3'd2;
    localparam logic [KIND_W-1:0] KIND_LUI    = 3'd3;
    localparam logic [KIND_W-1:0] KIND_AUIPC  = 3'd4;
    localparam logic [KIND_W-1:0] KIND_JAL    = 3'd5;
    localparam logic [KIND_W-1:0] KIND_JALR   = 3'd6;
    localparam logic [KIND_W-1:0] KIND_BRANCH = 3'd7;

    // alu operations
    localparam int ALU_OP_W = 4;
    localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd9;

endpackage

//--- design/rv_isa_pkg.sv
package rv_isa_pkg;

    // base opcodes kept by this core
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // branch conditions in funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] F7_ALT = 7'b0100000; // sub / sra / srai

    // one instruction word, read through each base format
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm_11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } inst_word_u;

endpackage
